// ==== common/vdp_settings.svh ====
`ifndef VDP_SETTINGS_SVH
`define VDP_SETTINGS_SVH

// ----------------------------------------
// CPU I/O port map
// ----------------------------------------
`define VDP_DATA_PORT     8'hBE
`define VDP_CTRL_PORT     8'hBF

// ----------------------------------------
// Memory sizes
// ----------------------------------------
`define VDP_VRAM_DEPTH    16384
`define VDP_CRAM_DEPTH    32

// ----------------------------------------
// Register file layout
// ----------------------------------------
`define VDP_NUM_REGS      10
`define VDP_REG_MODE2     1     // Mode register 2
`define VDP_DISP_EN_BIT   6     // Display enable in mode register 2
`define VDP_REG_BACKDROP  7
`define VDP_BACKDROP_BASE 16    // Sprite palette half of CRAM
`define VDP_COLOR_STEP    5     // 2-bit level to 4-bit channel

`endif

// ==== common/vdp_pkg.sv ====
package vdp_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [13:0] vram_addr_t;
  typedef logic [4:0]  cram_addr_t;
  typedef logic [3:0]  reg_index_t;
  typedef logic [3:0]  channel_t;

  // Blue in 5:4, green in 3:2, red in 1:0
  typedef logic [5:0]  palette_t;

  // Access code from bits 7:6 of the second control byte
  typedef enum logic [1:0] {
    CODE_VRAM_READ  = 2'd0,
    CODE_VRAM_WRITE = 2'd1,
    CODE_REG_WRITE  = 2'd2,
    CODE_CRAM_WRITE = 2'd3
  } vdp_code_e;

  // I/O cycle tracking
  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_ACTIVE,
    BUS_RELEASE
  } bus_state_e;

  // Read-ahead fill sequencing
  typedef enum logic [1:0] {
    CTL_IDLE,
    CTL_FETCH,
    CTL_FILL
  } ctl_state_e;

endpackage

// ==== cpu_port/vdp_bus_decoder.sv ====
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_bus_decoder import vdp_pkg::*; (
  input  logic  clk,
  input  logic  rst_L,
  input  byte_t addr,
  input  byte_t data_in,
  input  logic  iorq_L,
  input  logic  rd_L,
  input  logic  wr_L,
  output logic  data_wr,
  output logic  data_rd,
  output logic  ctrl_wr,
  output byte_t wr_byte,
  output logic  data_oe
);

  bus_state_e state, next_state;
  logic       is_ctrl;      // Cycle targets the control port
  logic       is_rd;        // Cycle is a CPU read
  logic       cycle_start;
  logic       strobes_high;
  logic       in_release;

  assign cycle_start  = !iorq_L && (!rd_L || !wr_L) &&
                        ((addr == `VDP_DATA_PORT) || (addr == `VDP_CTRL_PORT));
  assign strobes_high = iorq_L && rd_L && wr_L;

  always_comb begin
    case (state)
      BUS_IDLE:    next_state = cycle_start ? BUS_ACTIVE : BUS_IDLE;
      BUS_ACTIVE:  next_state = strobes_high ? BUS_RELEASE : BUS_ACTIVE;
      BUS_RELEASE: next_state = BUS_IDLE;
      default:     next_state = BUS_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state   <= BUS_IDLE;
      is_ctrl <= 1'b0;
      is_rd   <= 1'b0;
    end else begin
      state <= next_state;
      if (state == BUS_IDLE && cycle_start) begin
        is_ctrl <= (addr == `VDP_CTRL_PORT);
        is_rd   <= !rd_L;
      end
    end
  end

  // Write data held for the whole cycle
  always_ff @(posedge clk) begin
    if (state == BUS_IDLE && cycle_start)
      wr_byte <= data_in;
  end

  // ----------------------------------------
  // One pulse per cycle, after release
  // ----------------------------------------
  assign in_release = (state == BUS_RELEASE);
  assign data_wr    = in_release && !is_ctrl && !is_rd;
  assign data_rd    = in_release && !is_ctrl && is_rd;
  assign ctrl_wr    = in_release && is_ctrl && !is_rd;  // Control port reads ignored

  assign data_oe = (state == BUS_ACTIVE) && is_rd && !is_ctrl;

  // CPU never reads and writes in the same I/O cycle
  a_one_direction: assert property (
    @(posedge clk) disable iff (!rst_L) !iorq_L |-> (rd_L || wr_L)
  );

endmodule

// ==== cpu_port/vdp_port_control.sv ====
`timescale 1ns/100ps

module vdp_port_control import vdp_pkg::*; (
  input  logic       clk,
  input  logic       rst_L,
  input  logic       data_wr,
  input  logic       data_rd,
  input  logic       ctrl_wr,
  input  byte_t      wr_byte,
  input  byte_t      vram_rdata,
  output byte_t      read_buf,
  output vram_addr_t vram_addr,
  output logic       vram_we,
  output byte_t      vram_wdata,
  output cram_addr_t cram_addr,
  output logic       cram_we,
  output byte_t      cram_wdata,
  output logic       reg_we,
  output reg_index_t reg_index,
  output byte_t      reg_wdata
);

  ctl_state_e state;
  vdp_code_e  code;
  vdp_code_e  new_code;
  logic       first_byte;   // High while the latch expects the first byte
  logic       second_byte;
  byte_t      low_byte;
  vram_addr_t addr_cnt;

  assign second_byte = ctrl_wr && !first_byte;
  assign new_code    = vdp_code_e'(wr_byte[7:6]);

  // ----------------------------------------
  // Control latch and address counter
  // ----------------------------------------
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      first_byte <= 1'b1;
      code       <= CODE_VRAM_READ;
      addr_cnt   <= '0;
    end else begin
      if (ctrl_wr)
        first_byte <= !first_byte;
      if (second_byte) begin
        addr_cnt <= {wr_byte[5:0], low_byte};
        code     <= new_code;
      end else if (data_wr || state == CTL_FILL) begin
        addr_cnt <= addr_cnt + 1'b1;  // Wraps at 14 bits
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl_wr && first_byte)
      low_byte <= wr_byte;
  end

  // ----------------------------------------
  // Read-ahead fill
  // ----------------------------------------
  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      state <= CTL_IDLE;
    end else begin
      case (state)
        CTL_IDLE: begin
          if (data_rd || (second_byte && new_code == CODE_VRAM_READ))
            state <= CTL_FETCH;
        end
        CTL_FETCH: state <= CTL_FILL;  // VRAM samples the settled address
        default:   state <= CTL_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == CTL_FILL)
      read_buf <= vram_rdata;
  end

  // Writes land in the same clock as the decoder pulse
  assign vram_addr  = addr_cnt;
  assign vram_wdata = wr_byte;
  assign vram_we    = data_wr && (code != CODE_CRAM_WRITE);

  assign cram_addr  = addr_cnt[4:0];
  assign cram_wdata = wr_byte;
  assign cram_we    = data_wr && (code == CODE_CRAM_WRITE);

  assign reg_we     = second_byte && (new_code == CODE_REG_WRITE);
  assign reg_index  = wr_byte[3:0];
  assign reg_wdata  = low_byte;

  // No new access while a read fill is still running
  a_fill_idle: assert property (
    @(posedge clk) disable iff (!rst_L) (data_wr || data_rd || ctrl_wr) |-> state == CTL_IDLE
  );

endmodule

// ==== source/vdp_reg_file.sv ====
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_reg_file import vdp_pkg::*; (
  input  logic       clk,
  input  logic       rst_L,
  input  logic       reg_we,
  input  reg_index_t reg_index,
  input  byte_t      reg_wdata,
  output logic       disp_enable,
  output reg_index_t backdrop_sel
);

  byte_t regs [`VDP_NUM_REGS];

  // Indexes past the last register match no entry
  genvar i;
  generate
    for (i = 0; i < `VDP_NUM_REGS; i++) begin : g_reg
      always_ff @(posedge clk, negedge rst_L) begin
        if (!rst_L)
          regs[i] <= '0;
        else if (reg_we && reg_index == reg_index_t'(i))
          regs[i] <= reg_wdata;
      end
    end
  endgenerate

  assign disp_enable  = regs[`VDP_REG_MODE2][`VDP_DISP_EN_BIT];
  assign backdrop_sel = regs[`VDP_REG_BACKDROP][3:0];   // Low nibble only

endmodule

// ==== source/vdp_video_ram.sv ====
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_video_ram import vdp_pkg::*; (
  input  logic       clk,
  input  vram_addr_t vram_addr,
  input  logic       vram_we,
  input  byte_t      vram_wdata,
  output byte_t      vram_rdata,
  input  cram_addr_t cram_addr,
  input  logic       cram_we,
  input  byte_t      cram_wdata,
  input  cram_addr_t cram_rd_addr,
  output palette_t   cram_rd_data
);

  byte_t    vram [`VDP_VRAM_DEPTH];
  palette_t cram [`VDP_CRAM_DEPTH];

  // ----------------------------------------
  // VRAM, single port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (vram_we)
      vram[vram_addr] <= vram_wdata;
    vram_rdata <= vram[vram_addr];   // One clock read
  end

  // ----------------------------------------
  // CRAM, write port and backdrop read port
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (cram_we)
      cram[cram_addr] <= cram_wdata[5:0];   // Top two bits not stored
  end

  always_ff @(posedge clk) begin
    cram_rd_data <= cram[cram_rd_addr];
  end

endmodule

// ==== source/vdp_backdrop.sv ====
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_backdrop import vdp_pkg::*; (
  input  logic       clk,
  input  logic       rst_L,
  input  logic       disp_enable,
  input  reg_index_t backdrop_sel,
  output cram_addr_t cram_rd_addr,
  input  palette_t   cram_rd_data,
  output channel_t   backdrop_r,
  output channel_t   backdrop_g,
  output channel_t   backdrop_b
);

  logic disp_en_q;   // Lines up with the CRAM read

  // Backdrop always comes from the sprite palette
  assign cram_rd_addr = cram_addr_t'(`VDP_BACKDROP_BASE) + cram_addr_t'(backdrop_sel);

  // Levels 0..3 become 0, 5, 10, 15
  function automatic channel_t expand(input logic [1:0] level);
    expand = channel_t'(level) * channel_t'(`VDP_COLOR_STEP);
  endfunction

  always_ff @(posedge clk, negedge rst_L) begin
    if (!rst_L) begin
      disp_en_q  <= 1'b0;
      backdrop_r <= '0;
      backdrop_g <= '0;
      backdrop_b <= '0;
    end else begin
      disp_en_q <= disp_enable;
      if (disp_en_q) begin
        backdrop_r <= expand(cram_rd_data[1:0]);
        backdrop_g <= expand(cram_rd_data[3:2]);
        backdrop_b <= expand(cram_rd_data[5:4]);
      end else begin
        backdrop_r <= '0;   // Blanked display
        backdrop_g <= '0;
        backdrop_b <= '0;
      end
    end
  end

endmodule

// ==== source/vdp_top.sv ====
`timescale 1ns/100ps

module vdp_top import vdp_pkg::*; (
  input  logic     clk,
  input  logic     rst_L,
  input  byte_t    addr,
  input  byte_t    data_in,
  input  logic     iorq_L,
  input  logic     rd_L,
  input  logic     wr_L,
  output byte_t    data_out,
  output logic     data_oe,
  output channel_t backdrop_r,
  output channel_t backdrop_g,
  output channel_t backdrop_b
);

  // Decoder to port control
  logic       data_wr, data_rd, ctrl_wr;
  byte_t      wr_byte;

  // Port control to memories and registers
  vram_addr_t vram_addr;
  logic       vram_we;
  byte_t      vram_wdata, vram_rdata;
  cram_addr_t cram_addr;
  logic       cram_we;
  byte_t      cram_wdata;
  logic       reg_we;
  reg_index_t reg_index;
  byte_t      reg_wdata;

  // Backdrop path
  logic       disp_enable;
  reg_index_t backdrop_sel;
  cram_addr_t cram_rd_addr;
  palette_t   cram_rd_data;

  vdp_bus_decoder decoder0 (
    .clk, .rst_L,
    .addr, .data_in,
    .iorq_L, .rd_L, .wr_L,
    .data_wr, .data_rd, .ctrl_wr,
    .wr_byte,
    .data_oe
  );

  vdp_port_control port0 (
    .clk, .rst_L,
    .data_wr, .data_rd, .ctrl_wr,
    .wr_byte,
    .vram_rdata,
    .read_buf(data_out),  // Buffer drives the bus while data_oe is high
    .vram_addr, .vram_we, .vram_wdata,
    .cram_addr, .cram_we, .cram_wdata,
    .reg_we, .reg_index, .reg_wdata
  );

  vdp_reg_file regs0 (
    .clk, .rst_L,
    .reg_we, .reg_index, .reg_wdata,
    .disp_enable, .backdrop_sel
  );

  vdp_video_ram mem0 (
    .clk,
    .vram_addr, .vram_we, .vram_wdata, .vram_rdata,
    .cram_addr, .cram_we, .cram_wdata,
    .cram_rd_addr, .cram_rd_data
  );

  vdp_backdrop backdrop0 (
    .clk, .rst_L,
    .disp_enable, .backdrop_sel,
    .cram_rd_addr, .cram_rd_data,
    .backdrop_r, .backdrop_g, .backdrop_b
  );

endmodule

// ==== testbench/vdp_tb_clock.sv ====
`timescale 1ns/100ps

module vdp_tb_clock (
  output logic clk,
  output logic rst_L
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  initial begin
    rst_L = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_L = 1'b1;
  end

endmodule

// ==== testbench/vdp_tb.sv ====
`timescale 1ns/100ps
`include "vdp_settings.svh"

module vdp_tb import vdp_pkg::*; ();

  logic       clk, rst_L;
  byte_t      addr, data_in, data_out;
  logic       iorq_L, rd_L, wr_L, data_oe;
  channel_t   backdrop_r, backdrop_g, backdrop_b;

  logic [7:0] op_q[$];        // Operation letter per case
  int         a_q[$], b_q[$], c_q[$];
  logic [7:0] lfsr_state = 8'd98;
  int         cycle_cnt = 0;
  int         cycle_limit = 100;

  vdp_tb_clock clock0 (.clk, .rst_L);

  vdp_top dut0 (
    .clk, .rst_L, .addr, .data_in, .iorq_L, .rd_L, .wr_L,
    .data_out, .data_oe, .backdrop_r, .backdrop_g, .backdrop_b
  );

  // ----------------------------------------
  // Failure handling and compares
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_byte(input byte_t actual, input byte_t expected, input string what);
    if (actual !== expected) begin
      $display("FAIL at %0t: %s read %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_color(input channel_t actual, input channel_t expected,
                             input string chan);
    if (actual !== expected) begin
      $display("FAIL at %0t: backdrop %s is %0d, expected %0d", $time, chan, actual, expected);
      stop_with_failure();
    end
  endtask

  // Galois LFSR with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic idle_gap();
    int extra;
    extra = 0;
    repeat (2) begin
      extra      = (extra << 1) | lfsr_state[0];   // One step per bit
      lfsr_state = lfsr_next(lfsr_state);
    end
    repeat (3 + extra) @(posedge clk);
  endtask

  // ----------------------------------------
  // Bus cycles
  // ----------------------------------------
  task automatic port_write(input byte_t port, input byte_t value);
    @(posedge clk);
    #1;
    addr    = port;
    data_in = value;
    iorq_L  = 1'b0;
    wr_L    = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    if (data_oe) begin
      $display("data_oe went high during a port write at %0t", $time);
      stop_with_failure();
    end
    iorq_L = 1'b1;
    wr_L   = 1'b1;
    idle_gap();
  endtask

  task automatic data_read(input byte_t expected);
    @(posedge clk);
    #1;
    addr   = `VDP_DATA_PORT;
    iorq_L = 1'b0;
    rd_L   = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    if (!data_oe) begin
      $display("data_oe stayed low during a data port read at %0t", $time);
      stop_with_failure();
    end
    check_byte(data_out, expected, "data port");
    @(posedge clk);
    #1;
    iorq_L = 1'b1;
    rd_L   = 1'b1;
    idle_gap();
  endtask

  task automatic backdrop_check(input channel_t r, input channel_t g, input channel_t b);
    repeat (6) @(posedge clk);
    #1;
    check_color(backdrop_r, r, "red");
    check_color(backdrop_g, g, "green");
    check_color(backdrop_b, b, "blue");
  endtask

  task automatic load_cases();
    int         fd, n;
    logic [7:0] op;
    int         v0, v1, v2;
    string      rest;
    logic       ok;
    fd = $fopen("testbench/vdp_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file testbench/vdp_cases.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1)
        break;
      v0 = 0;
      v1 = 0;
      v2 = 0;
      ok = 1'b1;
      case (op)
        "#": n = $fgets(rest, fd);   // Comment line
        "W": ok = ($fscanf(fd, "%h %h", v0, v1) == 2);
        "R": ok = ($fscanf(fd, "%h", v0) == 1);
        "B": ok = ($fscanf(fd, "%d %d %d", v0, v1, v2) == 3);
        default: begin
          $display("Unknown operation '%c' in the case file", op);
          stop_with_failure();
        end
      endcase
      if (!ok) begin
        $display("Malformed '%c' line in the case file", op);
        stop_with_failure();
      end
      if (op != "#") begin
        op_q.push_back(op);
        a_q.push_back(v0);
        b_q.push_back(v1);
        c_q.push_back(v2);
      end
    end
    $fclose(fd);
  endtask

  // Run limit grows with the case count
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      stop_with_failure();
    end
  end

  initial begin
    addr    = '0;
    data_in = '0;
    iorq_L  = 1'b1;
    rd_L    = 1'b1;
    wr_L    = 1'b1;
    load_cases();
    cycle_limit = op_q.size() * 20 + 100;
    wait (rst_L);
    foreach (op_q[i]) begin
      case (op_q[i])
        "W": port_write(byte_t'(a_q[i]), byte_t'(b_q[i]));
        "R": data_read(byte_t'(a_q[i]));
        default: backdrop_check(channel_t'(a_q[i]), channel_t'(b_q[i]), channel_t'(c_q[i]));
      endcase
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== testbench/vdp_cases.txt ====
# W <port hex> <byte hex> is an I/O write, R <byte hex> a data port read
# B <r> <g> <b> checks the backdrop channels in decimal
B 0 0 0
# VRAM 0x0100 write with code 1, then read back with code 0
W bf 00
W bf 41
W be 11
W be 22
W be 33
W bf 00
W bf 01
R 11
R 22
R 33
# Address wrap from 0x3fff to 0x0000
W bf ff
W bf 7f
W be a5
W be 5a
W bf ff
W bf 3f
R a5
R 5a
# Backdrop select 3, display on, CRAM entry 19
W bf 03
W bf 87
W bf 40
W bf 81
W bf 13
W bf c0
W be 1b
B 15 10 5
# Register index 12 does not exist
W bf 00
W bf 8c
B 15 10 5
W bf 00
W bf 81
B 0 0 0
# Cycles at other ports are ignored
W bf 01
W bf 01
W 7f ff
W bd 77
W 10 99
R 22
R 33

// ==== sources.f ====
+incdir+common
common/vdp_pkg.sv
cpu_port/vdp_bus_decoder.sv
cpu_port/vdp_port_control.sv
source/vdp_reg_file.sv
source/vdp_video_ram.sv
source/vdp_backdrop.sv
source/vdp_top.sv
testbench/vdp_tb_clock.sv
testbench/vdp_tb.sv
